//--- Makefile
TOP = tb_exec_top

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f files.f

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

//--- alu_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

module alu_stage import exec_pkg::*;
(
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire                     i_clear,
        input  wire                     i_data_stall,
        exec_stage_if.consumer          i_stage,
        output logic [31:0]             o_alu_value_nxt,
        output logic                    o_alu_dav_nxt,
        output logic [31:0]             o_result,
        output logic                    o_result_valid,
        output logic [`EXEC_IDX_W-1:0]  o_result_index,
        output logic                    o_carry
);

logic logic_carry;
logic carry_nxt;

// Shifter carry, or the incoming flag when the shifter left it alone.
assign logic_carry = i_stage.use_old_carry ? i_stage.carry_in : i_stage.shift_carry;

always_comb
begin
        carry_nxt = logic_carry;
        case (i_stage.alu_op)
        ALU_ADD: {carry_nxt, o_alu_value_nxt} = {1'b0, i_stage.alu_source_value} +
                                                {1'b0, i_stage.shifted_value};
        // Carry out is NOT borrow.
        ALU_SUB: {carry_nxt, o_alu_value_nxt} = {1'b0, i_stage.alu_source_value} +
                                                {1'b0, ~i_stage.shifted_value} + 33'd1;
        ALU_AND: o_alu_value_nxt = i_stage.alu_source_value & i_stage.shifted_value;
        ALU_ORR: o_alu_value_nxt = i_stage.alu_source_value | i_stage.shifted_value;
        ALU_EOR: o_alu_value_nxt = i_stage.alu_source_value ^ i_stage.shifted_value;
        default: o_alu_value_nxt = i_stage.shifted_value;
        endcase
end

assign o_alu_dav_nxt = i_stage.valid;

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                o_result_valid <= 1'b0;
        end
        else if (!i_data_stall)
        begin
                o_result_valid <= i_stage.valid;
                o_result       <= o_alu_value_nxt;
                o_result_index <= i_stage.dest_index;
                o_carry        <= carry_nxt;
        end
end

endmodule

`default_nettype wire

//--- barrel_shifter.sv
`default_nettype none
`timescale 1ns/1ps

module barrel_shifter import exec_pkg::*;
(
        input  wire [31:0]      i_source,
        input  wire [7:0]       i_amount,
        input  wire shift_op_t  i_shift_type,
        input  wire             i_carry,
        output logic [31:0]     o_result,
        output logic            o_carry,
        output logic            o_use_old_carry
);

logic [63:0] rot_wide;

// Rotate only looks at the low five bits of the amount.
assign rot_wide = {i_source, i_source} >> i_amount[4:0];

always_comb
begin
        o_result        = i_source;
        o_carry         = i_carry;
        o_use_old_carry = 1'b0;

        if ((i_shift_type != SH_RRX) && (i_amount == 8'd0))
        begin
                // Zero amount, value and carry pass unchanged.
                o_use_old_carry = 1'b1;
        end
        else
        begin
                case (i_shift_type)
                SH_LSL:
                begin
                        // Carry is the last bit out; 32 gives bit 0, beyond is zero.
                        {o_carry, o_result} = {1'b0, i_source} << i_amount;
                end
                SH_LSR:
                begin
                        {o_result, o_carry} = {i_source, 1'b0} >> i_amount;
                end
                SH_ASR:
                begin
                        // Sign fills everything at 32 and above.
                        {o_result, o_carry} = $signed({i_source, 1'b0}) >>> i_amount;
                end
                SH_ROR:
                begin
                        o_result = rot_wide[31:0];
                        o_carry  = rot_wide[31];
                end
                SH_RRX:
                begin
                        o_result = {i_carry, i_source[31:1]};
                        o_carry  = i_source[0];
                end
                default:
                begin
                        o_use_old_carry = 1'b1;
                end
                endcase
        end
end

endmodule

`default_nettype wire

//--- exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// ============================================================
// Register file geometry.
// ============================================================

// Physical registers seen by the execute stages.
`define EXEC_PHY_REGS 16

// Index width for one physical register.
`define EXEC_IDX_W 4

// ============================================================
// Multiplier.
// ============================================================

// One step per 8-bit slice of the multiplier operand.
`define EXEC_MAC_STEPS 4

`endif

//--- exec_pkg.sv
`default_nettype none

`include "exec_consts.svh"

package exec_pkg;

        // ALU operations. MLA never reaches the ALU, it becomes MOV.
        typedef enum logic [2:0] {
                ALU_MOV,
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_ORR,
                ALU_EOR,
                ALU_MLA
        } alu_op_t;

        // Register-specified shift types.
        typedef enum logic [2:0] {
                SH_LSL,
                SH_LSR,
                SH_ASR,
                SH_ROR,
                SH_RRX
        } shift_op_t;

        // One operand word. The enable bit picks the view.
        typedef union packed {
                struct packed {
                        logic        en;
                        logic [31:0] value;
                } imm;
                struct packed {
                        logic                     en;
                        logic [31-`EXEC_IDX_W:0]  pad;
                        logic [`EXEC_IDX_W-1:0]   index;
                } rf;
        } operand_src_t;

endpackage

`default_nettype wire

//--- exec_stage_if.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

interface exec_stage_if import exec_pkg::*; ();

        logic                   valid;
        alu_op_t                alu_op;
        logic [`EXEC_IDX_W-1:0] dest_index;
        logic [31:0]            alu_source_value;
        logic [31:0]            shifted_value;
        logic                   shift_carry;
        logic                   use_old_carry;
        logic                   carry_in;

        // Shift stage side.
        modport producer (
                output valid, alu_op, dest_index, alu_source_value,
                output shifted_value, shift_carry, use_old_carry, carry_in
        );

        // ALU stage side, sampling only.
        modport consumer (
                input valid, alu_op, dest_index, alu_source_value,
                input shifted_value, shift_carry, use_old_carry, carry_in
        );

endinterface

`default_nettype wire

//--- exec_sva.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_sva
(
        input  wire             i_clk,
        input  wire             i_reset,
        input  wire             i_clear,
        input  wire             i_data_stall,
        input  wire             i_valid,
        input  wire [2:0]       i_alu_op,
        input  wire [2:0]       i_shift_op,
        input  wire [`EXEC_IDX_W-1:0] i_dest_index,
        input  wire [32:0]      i_alu_src,
        input  wire [32:0]      i_shift_src,
        input  wire [32:0]      i_rh_src,
        input  wire [31:0]      i_alu_source_value,
        input  wire [31:0]      i_shift_source_value,
        input  wire [31:0]      i_rh_value,
        input  wire [7:0]       i_shift_amount,
        input  wire             i_disable_shifter,
        input  wire             i_carry_in,
        input  wire             o_result_valid,
        input  wire             o_stall
);

logic [215:0] issue_bus;
int           stall_run;

assign issue_bus = {i_valid, i_alu_op, i_shift_op, i_dest_index, i_alu_src, i_shift_src,
                    i_rh_src, i_alu_source_value, i_shift_source_value, i_rh_value,
                    i_shift_amount, i_disable_shifter, i_carry_in};

// Stall cycles that actually advance the multiplier.
always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear || !o_stall)
                stall_run <= 0;
        else if (!i_data_stall)
                stall_run <= stall_run + 1;
end

// ============================================================
// Stall and clear protocol.
// ============================================================

a_empty_after_clear: assert property (@(posedge i_clk)
        (i_reset || i_clear) |=> !o_result_valid)
        else $error("result valid right after reset or clear");

a_stall_length: assert property (@(posedge i_clk) disable iff (i_reset)
        stall_run <= `EXEC_MAC_STEPS)
        else $error("multiply stall too long");

a_issue_held: assert property (@(posedge i_clk) disable iff (i_reset)
        (o_stall && $past(o_stall)) |-> $stable(issue_bus))
        else $error("issue inputs changed during stall");

endmodule

`default_nettype wire

//--- exec_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

module exec_top import exec_pkg::*;
(
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire                     i_clear,
        input  wire                     i_data_stall,
        input  wire                     i_valid,
        input  wire alu_op_t            i_alu_op,
        input  wire shift_op_t          i_shift_op,
        input  wire [`EXEC_IDX_W-1:0]   i_dest_index,
        input  wire operand_src_t       i_alu_src,
        input  wire operand_src_t       i_shift_src,
        input  wire operand_src_t       i_rh_src,
        input  wire [31:0]              i_alu_source_value,
        input  wire [31:0]              i_shift_source_value,
        input  wire [31:0]              i_rh_value,
        input  wire [7:0]               i_shift_amount,
        input  wire                     i_disable_shifter,
        input  wire                     i_carry_in,
        output logic [31:0]             o_result,
        output logic                    o_result_valid,
        output logic [`EXEC_IDX_W-1:0]  o_result_index,
        output logic                    o_carry,
        output logic                    o_stall
);

logic [31:0] alu_value_nxt;
logic        alu_dav_nxt;

exec_stage_if u_stage_if ();

shift_stage u_shift
(
        .i_clk                (i_clk),
        .i_reset              (i_reset),
        .i_clear              (i_clear),
        .i_data_stall         (i_data_stall),
        .i_valid              (i_valid),
        .i_alu_op             (i_alu_op),
        .i_shift_op           (i_shift_op),
        .i_dest_index         (i_dest_index),
        .i_alu_src            (i_alu_src),
        .i_shift_src          (i_shift_src),
        .i_rh_src             (i_rh_src),
        .i_alu_source_value   (i_alu_source_value),
        .i_shift_source_value (i_shift_source_value),
        .i_rh_value           (i_rh_value),
        .i_shift_amount       (i_shift_amount),
        .i_disable_shifter    (i_disable_shifter),
        .i_carry_in           (i_carry_in),
        .i_alu_value_nxt      (alu_value_nxt),
        .i_alu_dav_nxt        (alu_dav_nxt),
        .o_stage              (u_stage_if.producer),
        .o_stall              (o_stall)
);

// Same-cycle forwarding loops back from here.
alu_stage u_alu
(
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_clear         (i_clear),
        .i_data_stall    (i_data_stall),
        .i_stage         (u_stage_if.consumer),
        .o_alu_value_nxt (alu_value_nxt),
        .o_alu_dav_nxt   (alu_dav_nxt),
        .o_result        (o_result),
        .o_result_valid  (o_result_valid),
        .o_result_index  (o_result_index),
        .o_carry         (o_carry)
);

endmodule

`default_nettype wire

//--- files.f
+incdir+.
exec_pkg.sv
exec_stage_if.sv
operand_resolver.sv
barrel_shifter.sv
mac_unit.sv
shift_stage.sv
alu_stage.sv
exec_top.sv
exec_sva.sv
tb_exec_top.sv

//--- mac_unit.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

module mac_unit
(
        input  wire             i_clk,
        input  wire             i_reset,
        input  wire             i_clear,
        input  wire             i_data_stall,
        input  wire             i_start,
        input  wire [31:0]      i_rm,
        input  wire [31:0]      i_rs,
        input  wire [31:0]      i_rn,
        output logic            o_busy,
        output logic [31:0]     o_rd,
        output logic            o_nozero
);

localparam int CNT_W = $clog2(`EXEC_MAC_STEPS + 1);

logic [CNT_W-1:0] count;
logic [31:0]      acc;
logic [31:0]      rm_q;
logic [31:0]      rs_q;
logic [31:0]      partial;

assign o_busy = (count != '0);

// Current 8-bit slice of rs against rm, already aligned.
assign partial  = rm_q * {24'd0, rs_q[7:0]};

// Final sum is visible during the last busy cycle.
assign o_rd     = o_busy ? acc + partial : acc;
assign o_nozero = (o_rd != 32'd0);

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                count <= '0;
        end
        else if (i_data_stall)
        begin
                // Frozen.
        end
        else if (o_busy)
        begin
                count <= count - 1'b1;
                acc   <= o_rd;
                rm_q  <= rm_q << 8;
                rs_q  <= rs_q >> 8;
        end
        else if (i_start)
        begin
                count <= CNT_W'(`EXEC_MAC_STEPS);
                acc   <= i_rn;
                rm_q  <= i_rm;
                rs_q  <= i_rs;
        end
end

endmodule

`default_nettype wire

//--- operand_resolver.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

module operand_resolver import exec_pkg::*;
(
        input  wire operand_src_t           i_src,
        input  wire [31:0]                  i_issue_value,
        input  wire [`EXEC_IDX_W-1:0]       i_stage_index,
        input  wire [31:0]                  i_alu_value,
        input  wire                         i_alu_valid,
        output logic [31:0]                 o_value
);

// Immediate wins, then the in-flight ALU result, then the issued value.
always_comb
begin
        if (i_src.imm.en)
        begin
                o_value = i_src.imm.value;
        end
        else if (i_alu_valid && (i_src.rf.index == i_stage_index))
        begin
                // Issue read a stale copy, the ALU has the new one.
                o_value = i_alu_value;
        end
        else
        begin
                o_value = i_issue_value;
        end
end

endmodule

`default_nettype wire

//--- shift_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

module shift_stage import exec_pkg::*;
(
        input  wire                     i_clk,
        input  wire                     i_reset,
        input  wire                     i_clear,
        input  wire                     i_data_stall,

        // ============================================================
        // Issue side.
        // ============================================================
        input  wire                     i_valid,
        input  wire alu_op_t            i_alu_op,
        input  wire shift_op_t          i_shift_op,
        input  wire [`EXEC_IDX_W-1:0]   i_dest_index,
        input  wire operand_src_t       i_alu_src,
        input  wire operand_src_t       i_shift_src,
        input  wire operand_src_t       i_rh_src,
        input  wire [31:0]              i_alu_source_value,
        input  wire [31:0]              i_shift_source_value,
        input  wire [31:0]              i_rh_value,
        input  wire [7:0]               i_shift_amount,
        input  wire                     i_disable_shifter,
        input  wire                     i_carry_in,

        // Result the ALU is producing right now.
        input  wire [31:0]              i_alu_value_nxt,
        input  wire                     i_alu_dav_nxt,

        exec_stage_if.producer          o_stage,
        output logic                    o_stall
);

logic [31:0] alu_value_r;
logic [31:0] shift_src_r;
logic [31:0] rh_r;
logic [31:0] sh_result;
logic        sh_carry;
logic        sh_old_carry;
logic [31:0] mult_out;
logic        mac_busy;
logic        is_mla;
logic [31:0] shifted_nxt;
logic        valid_q;

// ============================================================
// Operand resolution against the ALU result.
// ============================================================

operand_resolver u_res_alu
(
        .i_src          (i_alu_src),
        .i_issue_value  (i_alu_source_value),
        .i_stage_index  (o_stage.dest_index),
        .i_alu_value    (i_alu_value_nxt),
        .i_alu_valid    (i_alu_dav_nxt),
        .o_value        (alu_value_r)
);

operand_resolver u_res_shift
(
        .i_src          (i_shift_src),
        .i_issue_value  (i_shift_source_value),
        .i_stage_index  (o_stage.dest_index),
        .i_alu_value    (i_alu_value_nxt),
        .i_alu_valid    (i_alu_dav_nxt),
        .o_value        (shift_src_r)
);

operand_resolver u_res_rh
(
        .i_src          (i_rh_src),
        .i_issue_value  (i_rh_value),
        .i_stage_index  (o_stage.dest_index),
        .i_alu_value    (i_alu_value_nxt),
        .i_alu_valid    (i_alu_dav_nxt),
        .o_value        (rh_r)
);

barrel_shifter u_shifter
(
        .i_source        (shift_src_r),
        .i_amount        (i_shift_amount),
        .i_shift_type    (i_shift_op),
        .i_carry         (i_carry_in),
        .o_result        (sh_result),
        .o_carry         (sh_carry),
        .o_use_old_carry (sh_old_carry)
);

assign is_mla = (i_alu_op == ALU_MLA);

// Rd = rm * rs + rn, with rh as the accumulator.
mac_unit u_mac
(
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_clear      (i_clear),
        .i_data_stall (i_data_stall),
        .i_start      (i_valid && is_mla),
        .i_rm         (alu_value_r),
        .i_rs         (shift_src_r),
        .i_rn         (rh_r),
        .o_busy       (mac_busy),
        .o_rd         (mult_out),
        .o_nozero     ()
);

assign o_stall = mac_busy;

// Held MLA looks like a bubble until the product is complete.
assign o_stage.valid = valid_q && !mac_busy;

always_comb
begin
        if (i_disable_shifter)
                shifted_nxt = shift_src_r;
        else
                shifted_nxt = sh_result;
end

// ============================================================
// Stage register.
// ============================================================

always_ff @(posedge i_clk)
begin
        if (i_reset || i_clear)
        begin
                valid_q <= 1'b0;
        end
        else if (i_data_stall)
        begin
                // Hold everything.
        end
        else if (mac_busy)
        begin
                // Keep the MLA in place, collect the running product.
                o_stage.shifted_value <= mult_out;
        end
        else
        begin
                valid_q                  <= i_valid;
                o_stage.alu_op           <= is_mla ? ALU_MOV : i_alu_op;
                o_stage.dest_index       <= i_dest_index;
                o_stage.alu_source_value <= alu_value_r;
                o_stage.shifted_value    <= shifted_nxt;
                o_stage.shift_carry      <= sh_carry;
                o_stage.use_old_carry    <= i_disable_shifter || is_mla || sh_old_carry;
                o_stage.carry_in         <= i_carry_in;
        end
end

endmodule

`default_nettype wire

//--- tb_exec_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "exec_consts.svh"

module tb_exec_top import exec_pkg::*; ();

localparam int N_SHIFT = 40;
localparam int N_MIX   = 80;
localparam int N_STALL = 60;
localparam int N_CLEAR = 17;
localparam int LIMIT   = (N_SHIFT + N_MIX + N_STALL + N_CLEAR) * (`EXEC_MAC_STEPS + 4);

logic i_clk, i_reset, i_clear, i_data_stall, i_valid;
alu_op_t i_alu_op;
shift_op_t i_shift_op;
logic [`EXEC_IDX_W-1:0] i_dest_index, o_result_index;
operand_src_t i_alu_src, i_shift_src, i_rh_src;
logic [31:0] i_alu_source_value, i_shift_source_value, i_rh_value, o_result;
logic [7:0] i_shift_amount;
logic i_disable_shifter, i_carry_in, o_result_valid, o_carry, o_stall;

logic [31:0] rf [`EXEC_PHY_REGS];
logic [31:0] rf_stale [`EXEC_PHY_REGS];
logic [31:0] exp_res [$];
logic [31:0] exp_old [$];
logic [3:0]  exp_idx [$];
logic        exp_carry [$];
logic        exp_stall [$];
logic [15:0] lfsr = 16'd56671;
logic        ahead_valid, stall_mode, out_held;
logic [3:0]  last_dest;

exec_top dut0 (.*);

bind exec_top exec_sva u_sva (.*);

always #20 i_clk = ~i_clk;

// ============================================================
// Helpers.
// ============================================================

function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
                lfsr = lfsr_next(lfsr);
                v    = {v[30:0], lfsr[0]};
        end
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("Fail %s: got %h, expected %h", name, got, exp);
                $display("Regression failed");
                $fatal(1);
        end
endtask

// Expected {carry, result} from the ARM shift and ALU rules.
function automatic logic [32:0] exec_model(input alu_op_t op, input shift_op_t shop,
        input logic [7:0] amt, input logic dis, input logic cin,
        input logic [31:0] a, input logic [31:0] s, input logic [31:0] h);
        logic [31:0] sh;
        logic        c;
        logic [31:0] r;
        int          n;
        int          k;
        sh = s;
        c  = cin;
        n  = int'(amt);
        if (op == ALU_MLA)
                return {cin, a * s + h};
        if (!dis && shop == SH_RRX)
        begin
                sh = {cin, s[31:1]};
                c  = s[0];
        end
        else if (!dis && n != 0)
        begin
                case (shop)
                SH_LSL:
                begin
                        sh = (n < 32) ? s << n : 32'd0;
                        c  = (n < 32) ? s[32-n] : ((n == 32) ? s[0] : 1'b0);
                end
                SH_LSR:
                begin
                        sh = (n < 32) ? s >> n : 32'd0;
                        c  = (n < 32) ? s[n-1] : ((n == 32) ? s[31] : 1'b0);
                end
                SH_ASR:
                begin
                        if (n < 32)
                                sh = $signed(s) >>> n;
                        else
                                sh = {32{s[31]}};
                        c  = (n < 32) ? s[n-1] : s[31];
                end
                default:
                begin
                        k  = n % 32;
                        sh = (k == 0) ? s : ((s >> k) | (s << (32 - k)));
                        c  = (k == 0) ? s[31] : s[k-1];
                end
                endcase
        end
        r = sh;
        case (op)
        ALU_ADD: {c, r} = {1'b0, a} + {1'b0, sh};
        ALU_SUB:
        begin
                r = a - sh;
                c = (a >= sh);
        end
        ALU_AND: r = a & sh;
        ALU_ORR: r = a | sh;
        ALU_EOR: r = a ^ sh;
        default: r = sh;
        endcase
        return {c, r};
endfunction

// Register operands often hit the instruction ahead, whose value is stale here.
task automatic pick_operand(input logic imm, output operand_src_t src,
        output logic [31:0] true_v, output logic [31:0] iss_v);
        logic [31:0] v;
        logic [31:0] r;
        logic [3:0]  idx;
        take_bits(32, v);
        take_bits(2, r);
        src = '0;
        if (imm)
        begin
                src.imm.en    = 1'b1;
                src.imm.value = v;
                true_v        = v;
                iss_v         = ~v;
        end
        else
        begin
                idx = (ahead_valid && r[1:0] != 2'd0) ? last_dest : v[3:0];
                src.rf.index = idx;
                true_v       = rf[idx];
                iss_v        = ahead_valid ? rf_stale[idx] : rf[idx];
        end
endtask

task automatic wait_accept();
        logic        acc;
        logic [31:0] r;
        acc = 1'b0;
        while (!acc)
        begin
                @(posedge i_clk);
                acc = !o_stall && !i_data_stall;
                take_bits(2, r);
                i_data_stall <= stall_mode && (r[1:0] == 2'd0);
        end
endtask

task automatic send(input alu_op_t op, input shift_op_t shop, input logic [7:0] amt,
        input logic dis, input logic [2:0] imm_mask);
        operand_src_t a_src, s_src, h_src;
        logic [31:0]  a_t, s_t, h_t, a_i, s_i, h_i, r;
        logic [32:0]  res;
        logic [3:0]   dest;
        logic         cin;
        pick_operand(imm_mask[0], a_src, a_t, a_i);
        pick_operand(imm_mask[1], s_src, s_t, s_i);
        pick_operand(imm_mask[2], h_src, h_t, h_i);
        take_bits(5, r);
        dest = r[3:0];
        cin  = r[4];
        res  = exec_model(op, shop, amt, dis, cin, a_t, s_t, h_t);
        i_valid              <= 1'b1;
        i_alu_op             <= op;
        i_shift_op           <= shop;
        i_dest_index         <= dest;
        i_alu_src            <= a_src;
        i_shift_src          <= s_src;
        i_rh_src             <= h_src;
        i_alu_source_value   <= a_i;
        i_shift_source_value <= s_i;
        i_rh_value           <= h_i;
        i_shift_amount       <= amt;
        i_disable_shifter    <= dis;
        i_carry_in           <= cin;
        wait_accept();
        exp_stall.push_back(op == ALU_MLA);
        exp_res.push_back(res[31:0]);
        exp_carry.push_back(res[32]);
        exp_idx.push_back(dest);
        exp_old.push_back(rf[dest]);
        rf_stale    = rf;
        rf[dest]    = res[31:0];
        ahead_valid = 1'b1;
        last_dest   = dest;
endtask

task automatic idle();
        i_valid      <= 1'b0;
        i_data_stall <= 1'b0;
        @(posedge i_clk);
        ahead_valid = 1'b0;
endtask

task automatic drain();
        while (exp_res.size() != 0)
                idle();
        idle();
endtask

// Discard everything in flight and roll the register model back.
task automatic discard();
        logic [3:0] idx;
        i_valid      <= 1'b0;
        i_data_stall <= 1'b0;
        i_clear      <= 1'b1;
        @(posedge i_clk);
        i_clear <= 1'b0;
        while (exp_res.size() != 0)
        begin
                idx     = exp_idx.pop_back();
                rf[idx] = exp_old.pop_back();
                void'(exp_res.pop_back());
                void'(exp_carry.pop_back());
        end
        ahead_valid = 1'b0;
endtask

task automatic send_random(input int count);
        logic [31:0] r;
        logic [7:0]  amt;
        alu_op_t     op;
        for (int i = 0; i < count; i++)
        begin
                take_bits(32, r);
                op  = (r[2:0] == 3'd7) ? ALU_MLA : alu_op_t'(r[5:3] % 6);
                amt = r[15] ? r[23:16] : 8'(r[23:16] % 40);
                send(op, shift_op_t'(r[8:6] % 5), amt, r[10:9] == 2'd0, r[13:11]);
        end
endtask

// ============================================================
// Result checker.
// ============================================================

always @(posedge i_clk)
        out_held <= i_data_stall;

always @(negedge i_clk)
begin
        // The multiplier stalls issue from the cycle after an MLA is accepted.
        if (exp_stall.size() != 0)
                check("o_stall", 32'(o_stall), 32'(exp_stall.pop_front()));
        if (!i_reset && o_result_valid && !out_held)
        begin
                if (exp_res.size() == 0)
                begin
                        $display("Result appeared with no instruction outstanding");
                        $display("Regression failed");
                        $fatal(1);
                end
                check("o_result", o_result, exp_res.pop_front());
                check("o_result_index", 32'(o_result_index), 32'(exp_idx.pop_front()));
                check("o_carry", 32'(o_carry), 32'(exp_carry.pop_front()));
                void'(exp_old.pop_front());
        end
end

initial
begin
        repeat (LIMIT) @(posedge i_clk);
        $display("Watchdog expired before the tests finished");
        $display("Regression failed");
        $fatal(1);
end

// ============================================================
// Stimulus.
// ============================================================

initial
begin
        logic [31:0] r;
        logic [7:0]  amts [8];
        i_clk = 1'b0;
        i_reset = 1'b1;
        i_clear = 1'b0;
        i_data_stall = 1'b0;
        i_valid = 1'b0;
        i_alu_op = ALU_MOV;
        i_shift_op = SH_LSL;
        i_dest_index = '0;
        i_alu_src = '0;
        i_shift_src = '0;
        i_rh_src = '0;
        i_alu_source_value = '0;
        i_shift_source_value = '0;
        i_rh_value = '0;
        i_shift_amount = '0;
        i_disable_shifter = 1'b0;
        i_carry_in = 1'b0;
        ahead_valid = 1'b0;
        stall_mode = 1'b0;
        last_dest = '0;
        for (int i = 0; i < `EXEC_PHY_REGS; i++)
                rf[i] = (32'h9E3779B9 * (i + 1)) ^ {i[7:0], 24'h5A3C96};
        rf_stale = rf;
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;

        // Shift types at the boundary amounts.
        for (int t = 0; t < 5; t++)
        begin
                take_bits(24, r);
                amts = '{8'd0, 8'd1, 8'd31, 8'd32, 8'd33, r[7:0], 8'(r[15:8] % 32), r[23:16]};
                for (int j = 0; j < 8; j++)
                begin
                        take_bits(3, r);
                        send(j[0] ? ALU_MOV : ALU_ADD, shift_op_t'(t), amts[j], 1'b0, r[2:0]);
                end
        end
        drain();

        send_random(N_MIX);
        drain();

        stall_mode = 1'b1;
        send_random(N_STALL);
        stall_mode = 1'b0;
        drain();

        // Clear with a fresh multiply, a half-done multiply, and plain instructions.
        send_random(3);
        send(ALU_MLA, SH_LSL, 8'd0, 1'b0, 3'b000);
        discard();
        send_random(2);
        send(ALU_MLA, SH_LSL, 8'd0, 1'b0, 3'b010);
        idle();
        idle();
        discard();
        send_random(4);
        discard();
        send_random(6);
        drain();

        $display("Regression passed");
        $finish;
end

endmodule

`default_nettype wire
